//--- flist.f
+incdir+verilog
+incdir+test
verilog/alloc_pkg.sv
verilog/alloc_dispatch.sv
verilog/linear_allocator.sv
verilog/grant_merge.sv
verilog/buffer_alloc_top.sv
test/tb_buffer_alloc.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the buffer allocator testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -f flist.f --top-module tb_buffer_alloc -o sim_tb

# A fatal stop returns nonzero, the log decides the result
./obj_dir/sim_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
	echo "Simulation failed"
	exit 1
fi

echo "Simulation passed"
exit 0

//--- test/alloc_vectors.svh
//==========================================================
// Allocator test vectors
// One row per operation, applied in order by the testbench
//==========================================================

`ifndef ALLOC_VECTORS_SVH
`define ALLOC_VECTORS_SVH

// Columns are op, bank, cfg id, false flag and arg
// arg is idle cycles for IDLE and the free cfg id for STALL
typedef struct packed {
	logic [2:0] op;
	logic [1:0] bank;
	logic [1:0] cfg;
	logic       fls;
	logic [3:0] arg;
} vec_t;

localparam logic [2:0] OP_IDLE  = 3'd0;
localparam logic [2:0] OP_ALLOC = 3'd1;
localparam logic [2:0] OP_STALL = 3'd2;
localparam logic [2:0] OP_FREE  = 3'd3;
localparam logic [2:0] OP_BLK   = 3'd4;
localparam logic [2:0] OP_HOLD  = 3'd5;

localparam int N_VEC = 20;

localparam vec_t VECS [N_VEC] = '{
	'{OP_IDLE, 2'd0, 2'd0, 1'b0, 4'd5},
	// Running sum on bank 0 and a full-bank wrap on bank 1
	'{OP_ALLOC, 2'd0, 2'd0, 1'b0, 4'd0}, '{OP_ALLOC, 2'd0, 2'd1, 1'b0, 4'd0},
	'{OP_ALLOC, 2'd0, 2'd1, 1'b0, 4'd0}, '{OP_ALLOC, 2'd1, 2'd3, 1'b0, 4'd0},
	'{OP_FREE, 2'd1, 2'd1, 1'b0, 4'd0}, '{OP_ALLOC, 2'd1, 2'd1, 1'b0, 4'd0},
	'{OP_ALLOC, 2'd0, 2'd1, 1'b0, 4'd0}, '{OP_ALLOC, 2'd0, 2'd1, 1'b0, 4'd0},
	'{OP_STALL, 2'd0, 2'd1, 1'b0, 4'd0},
	// False alloc on a full bank and a false free
	'{OP_ALLOC, 2'd1, 2'd3, 1'b1, 4'd0}, '{OP_FREE, 2'd1, 2'd3, 1'b1, 4'd0},
	'{OP_STALL, 2'd1, 2'd0, 1'b0, 4'd1},
	// Bank 2 advanced and bank 0 wrapped before the rewind
	'{OP_ALLOC, 2'd2, 2'd1, 1'b0, 4'd0}, '{OP_ALLOC, 2'd0, 2'd2, 1'b0, 4'd0},
	// Rewind
	'{OP_BLK, 2'd0, 2'd0, 1'b0, 4'd0}, '{OP_ALLOC, 2'd2, 2'd1, 1'b0, 4'd0},
	'{OP_ALLOC, 2'd1, 2'd0, 1'b0, 4'd0}, '{OP_STALL, 2'd0, 2'd0, 1'b0, 4'd1},
	// All banks under back-pressure
	'{OP_HOLD, 2'd0, 2'd2, 1'b0, 4'd0}
};

`endif

//--- test/tb_buffer_alloc.sv
//==========================================================
// Testbench for the multi-bank buffer allocator
// Table driven, with a capacity and cursor model per bank
//==========================================================

`timescale 1ns/1ps

`include "alloc_params.svh"

module tb_buffer_alloc;

	`include "alloc_vectors.svh"

	logic                  i_clk;
	logic                  i_rst_n;
	alloc_pkg::size_tab_t  i_sizes;
	logic                  i_alloc_rdy;
	alloc_pkg::alloc_req_t i_alloc;
	logic                  o_alloc_ack;
	logic                  i_free_dval;
	alloc_pkg::free_req_t  i_free;
	logic                  i_blkdone_dval;
	logic                  o_linear_rdy;
	alloc_pkg::grant_t     o_linear;
	logic                  i_linear_ack;

	// Model state
	int tab [4] = '{5, 12, 0, 64};
	int cap [4];
	int cur [4];
	// Expected grants per bank in issue order
	alloc_pkg::grant_t exp_q [4][$];
	integer seed = 96;

	buffer_alloc_top DUT (.*);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check(input string name, input int got, input int exp);
		if (got != exp) begin
			abort_run($sformatf("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp));
		end
	endtask

	function automatic bit queues_empty();
		return exp_q[0].size() == 0 && exp_q[1].size() == 0 &&
			exp_q[2].size() == 0 && exp_q[3].size() == 0;
	endfunction

	// Sampled at negedge and matched by bank field
	task automatic match_grant();
		alloc_pkg::grant_t e;
		int b;
		b = int'(o_linear.bank);
		check("grant pending for bank", int'(exp_q[b].size() > 0), 1);
		e = exp_q[b].pop_front();
		check("o_linear.addr", int'(o_linear.addr), int'(e.addr));
		check("o_linear.cfg", int'(o_linear.cfg), int'(e.cfg));
		check("o_linear.is_false", int'(o_linear.is_false), int'(e.is_false));
	endtask

	// Model update on an accepted request
	task automatic accept(input int b, input int c, input bit f);
		alloc_pkg::grant_t e;
		int sz;
		// False requests reserve nothing
		sz = f ? 0 : tab[c];
		e.bank = 2'(b);
		e.addr = 6'(cur[b]);
		e.cfg = 2'(c);
		e.is_false = f;
		exp_q[b].push_back(e);
		cap[b] = cap[b] - sz;
		// Cursor wraps over the 64 word bank
		cur[b] = (cur[b] + sz) % 64;
	endtask

	task automatic wait_ack();
		int t;
		for (t = 0; t < 50; t++) begin
			@(negedge i_clk);
			if (o_alloc_ack) break;
		end
		if (t == 50) abort_run("Timeout waiting for the alloc ack");
	endtask

	task automatic drain_grants();
		int t;
		for (t = 0; t < 50 && !queues_empty(); t++) begin
			@(negedge i_clk);
			if (o_linear_rdy) match_grant();
		end
		if (!queues_empty()) abort_run("Timeout waiting for a grant");
		// A taken grant leaves the output and never repeats
		@(negedge i_clk);
		check("o_linear_rdy after drain", int'(o_linear_rdy), 0);
	endtask

	// One-cycle free pulse
	task automatic pulse_free(input int b, input int c, input bit f);
		@(posedge i_clk);
		i_free_dval <= 1'b1;
		i_free <= '{bank: 2'(b), cfg: 2'(c), is_false: f};
		@(posedge i_clk);
		i_free_dval <= 1'b0;
		if (!f) cap[b] = cap[b] + tab[c];
	endtask

	// Stall rows release the request with a free of cfg fc
	task automatic do_alloc(input int b, input int c, input bit f, input bit stall, input int fc);
		check("model stall", int'(cap[b] < (f ? 0 : tab[c])), int'(stall));
		@(posedge i_clk);
		i_alloc_rdy <= 1'b1;
		i_alloc <= '{bank: 2'(b), cfg: 2'(c), is_false: f};
		if (stall) begin
			// No room, so the request must wait
			repeat (10) begin
				@(negedge i_clk);
				check("o_alloc_ack", int'(o_alloc_ack), 0);
			end
			pulse_free(b, fc, 1'b0);
		end
		wait_ack();
		accept(b, c, f);
		@(posedge i_clk);
		i_alloc_rdy <= 1'b0;
	endtask

	// Four grants held back before a second request to bank 0
	task automatic hold_all(input int c);
		int hold;
		int t;
		bit second_done;
		@(posedge i_clk);
		i_linear_ack <= 1'b0;
		for (int b = 0; b < 4; b++) do_alloc(b, c, 1'b0, 1'b0, 0);
		@(posedge i_clk);
		i_alloc_rdy <= 1'b1;
		i_alloc <= '{bank: 2'd0, cfg: 2'(c), is_false: 1'b0};
		hold = 3 + ($random(seed) & 7);
		// Bank 0 grant still pending
		repeat (hold) begin
			@(negedge i_clk);
			check("o_alloc_ack while grant pending", int'(o_alloc_ack), 0);
		end
		@(posedge i_clk);
		i_linear_ack <= 1'b1;
		second_done = 1'b0;
		for (t = 0; t < 100 && !(second_done && queues_empty()); t++) begin
			@(negedge i_clk);
			if (o_linear_rdy) match_grant();
			if (!second_done && o_alloc_ack) begin
				accept(0, c, 1'b0);
				second_done = 1'b1;
				@(posedge i_clk);
				i_alloc_rdy <= 1'b0;
			end
		end
		if (!(second_done && queues_empty())) abort_run("Timeout draining held grants");
	endtask

	initial begin
		vec_t v;
		i_rst_n = 1'b0;
		for (int k = 0; k < 4; k++) i_sizes[k] = 7'(tab[k]);
		i_alloc_rdy = 1'b0;
		i_alloc = '0;
		i_free_dval = 1'b0;
		i_free = '0;
		i_blkdone_dval = 1'b0;
		i_linear_ack = 1'b1;
		// Empty banks with cursors at zero
		for (int k = 0; k < 4; k++) begin
			cap[k] = 64;
			cur[k] = 0;
		end
		repeat (8) @(posedge i_clk);
		i_rst_n <= 1'b1;

		for (int r = 0; r < N_VEC; r++) begin
			v = VECS[r];
			case (v.op)
				OP_IDLE: begin
					repeat (int'(v.arg)) begin
						@(negedge i_clk);
						check("o_alloc_ack", int'(o_alloc_ack), 0);
						check("o_linear_rdy", int'(o_linear_rdy), 0);
					end
				end
				OP_ALLOC: do_alloc(int'(v.bank), int'(v.cfg), v.fls, 1'b0, 0);
				OP_STALL: do_alloc(int'(v.bank), int'(v.cfg), v.fls, 1'b1, int'(v.arg));
				OP_FREE:  pulse_free(int'(v.bank), int'(v.cfg), v.fls);
				OP_BLK: begin
					@(posedge i_clk);
					i_blkdone_dval <= 1'b1;
					@(posedge i_clk);
					i_blkdone_dval <= 1'b0;
					// Rewind moves every cursor and no capacity
					for (int k = 0; k < 4; k++) cur[k] = 0;
				end
				OP_HOLD:  hold_all(int'(v.cfg));
				default:  abort_run("Unknown operation in the vector table");
			endcase
			drain_grants();
		end

		$display("No errors");
		$finish;
	end

endmodule

//--- verilog/buffer_alloc_top.sv
//==========================================================
// Multi-bank local buffer allocator
// Dispatcher, one linear allocator per bank, grant merger
//==========================================================

`timescale 1ns/1ps

`include "alloc_params.svh"

module buffer_alloc_top (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  alloc_pkg::size_tab_t  i_sizes,
	// Alloc request channel
	input  logic                  i_alloc_rdy,
	input  alloc_pkg::alloc_req_t i_alloc,
	output logic                  o_alloc_ack,
	// Free and rewind pulses
	input  logic                  i_free_dval,
	input  alloc_pkg::free_req_t  i_free,
	input  logic                  i_blkdone_dval,
	// Merged grant channel
	output logic                  o_linear_rdy,
	output alloc_pkg::grant_t     o_linear,
	input  logic                  i_linear_ack
);

	// Dispatcher to banks
	logic [`ALLOC_N_BUF-1:0] bank_rdy;
	logic [`ALLOC_N_BUF-1:0] bank_ack;
	logic [`ALLOC_N_BUF-1:0] bank_free;
	// Banks to merger
	logic [`ALLOC_N_BUF-1:0] grant_rdy;
	logic [`ALLOC_N_BUF-1:0] grant_ack;
	alloc_pkg::grant_t       grant [`ALLOC_N_BUF];

	alloc_dispatch u_dispatch (
		.i_alloc_rdy (i_alloc_rdy),
		.i_alloc     (i_alloc),
		.o_alloc_ack (o_alloc_ack),
		.o_bank_rdy  (bank_rdy),
		.i_bank_ack  (bank_ack),
		.i_free_dval (i_free_dval),
		.i_free      (i_free),
		.o_bank_free (bank_free)
	);

	// One allocator per bank, table and rewind shared
	for (genvar g = 0; g < `ALLOC_N_BUF; g++) begin : g_bank
		linear_allocator u_alloc (
			.i_clk(i_clk), .i_rst_n(i_rst_n), .i_sizes(i_sizes),
			.i_alloc_rdy(bank_rdy[g]), .i_alloc(i_alloc), .o_alloc_ack(bank_ack[g]),
			.i_free_dval(bank_free[g]), .i_free(i_free), .i_blkdone_dval(i_blkdone_dval),
			.o_grant_rdy(grant_rdy[g]), .o_grant(grant[g]), .i_grant_ack(grant_ack[g])
		);
	end

	grant_merge u_merge (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_bank_rdy(grant_rdy), .i_bank_grant(grant), .o_bank_ack(grant_ack),
		.o_linear_rdy(o_linear_rdy), .o_linear(o_linear), .i_linear_ack(i_linear_ack)
	);

endmodule

//--- verilog/grant_merge.sv
//==========================================================
// Grant merger
// Round-robin selection of bank grants onto one output
//==========================================================

`timescale 1ns/1ps

`include "alloc_params.svh"

module grant_merge (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	// Bank grant channels
	input  logic [`ALLOC_N_BUF-1:0] i_bank_rdy,
	input  alloc_pkg::grant_t       i_bank_grant [`ALLOC_N_BUF],
	output logic [`ALLOC_N_BUF-1:0] o_bank_ack,
	// Merged output channel
	output logic                    o_linear_rdy,
	output alloc_pkg::grant_t       o_linear,
	input  logic                    i_linear_ack
);

	localparam int N_BUF = `ALLOC_N_BUF;
	localparam int BW    = `ALLOC_BUF_BW;

	logic [BW-1:0] ptr_r;
	logic [BW-1:0] sel_w;
	logic          hit_w;

	//==========================================================
	// Arbitration
	//==========================================================

	// First waiting bank at or after the pointer
	always_comb begin
		sel_w = ptr_r;
		hit_w = 1'b0;
		for (int k = 0; k < N_BUF; k++) begin
			if (!hit_w && i_bank_rdy[(int'(ptr_r) + k) % N_BUF]) begin
				hit_w = 1'b1;
				sel_w = BW'((int'(ptr_r) + k) % N_BUF);
			end
		end
	end

	assign o_linear_rdy = hit_w;
	assign o_linear     = i_bank_grant[sel_w];

	// Ack only the served bank, and only on a transfer
	always_comb begin
		o_bank_ack = '0;
		if (o_linear_rdy && i_linear_ack) begin
			o_bank_ack[sel_w] = 1'b1;
		end
	end

	// Pointer moves one past the served bank
	// held while the output is stalled
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			ptr_r <= '0;
		end else if (o_linear_rdy && i_linear_ack) begin
			ptr_r <= BW'((int'(sel_w) + 1) % N_BUF);
		end
	end

endmodule

//--- verilog/linear_allocator.sv
//==========================================================
// Linear allocator for one bank
// Tracks remaining capacity and a wrapping cursor, hands
// out the cursor on each accepted request
//==========================================================

`timescale 1ns/1ps

`include "alloc_params.svh"

module linear_allocator (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	// Shared size table
	input  alloc_pkg::size_tab_t  i_sizes,
	// Alloc channel
	input  logic                  i_alloc_rdy,
	input  alloc_pkg::alloc_req_t i_alloc,
	output logic                  o_alloc_ack,
	// Free pulse
	input  logic                  i_free_dval,
	input  alloc_pkg::free_req_t  i_free,
	// Rewind pulse
	input  logic                  i_blkdone_dval,
	// Grant channel
	output logic                  o_grant_rdy,
	output alloc_pkg::grant_t     o_grant,
	input  logic                  i_grant_ack
);

	localparam int LBW = `ALLOC_LBW;
	// Empty bank, 2**LBW words
	localparam logic [LBW:0] CAPACITY = (LBW+1)'(1) << LBW;

	//==========================================================
	// Internal
	//==========================================================
	logic [LBW:0]   cap_r;
	logic [LBW:0]   cap_w;
	logic [LBW-1:0] cur_r;
	logic [LBW:0]   asize;
	logic [LBW:0]   fsize;

	// False requests reserve and return nothing
	assign asize = i_alloc.is_false ? '0 : i_sizes[i_alloc.cfg];
	assign fsize = i_free.is_false  ? '0 : i_sizes[i_free.cfg];

	//==========================================================
	// Accept and capacity
	//==========================================================

	// Accept only with an empty grant slot and enough room
	// a pending grant blocks the next request
	assign o_alloc_ack = i_alloc_rdy && !o_grant_rdy && (cap_r >= asize);

	// Alloc and free can land in the same cycle
	always_comb begin
		cap_w = cap_r;
		if (o_alloc_ack) begin
			cap_w = cap_w - asize;
		end
		if (i_free_dval) begin
			cap_w = cap_w + fsize;
		end
	end

	//==========================================================
	// Sequential
	//==========================================================

	// Capacity and cursor
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			cap_r <= CAPACITY;
			cur_r <= '0;
		end else begin
			cap_r <= cap_w;
			// Rewind wins over an advance in the same cycle
			if (i_blkdone_dval) begin
				cur_r <= '0;
			end else if (o_alloc_ack) begin
				// Full bank size truncates to zero, wraps mod 2**LBW
				cur_r <= cur_r + asize[LBW-1:0];
			end
		end
	end

	// Grant valid, held until the merger takes it
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_grant_rdy <= 1'b0;
		end else if (o_alloc_ack) begin
			o_grant_rdy <= 1'b1;
		end else if (i_grant_ack) begin
			o_grant_rdy <= 1'b0;
		end
	end

	// Grant payload, captured on accept
	always_ff @(posedge i_clk) begin
		if (o_alloc_ack) begin
			o_grant.bank     <= i_alloc.bank;
			o_grant.addr     <= cur_r;
			o_grant.cfg      <= i_alloc.cfg;
			o_grant.is_false <= i_alloc.is_false;
		end
	end

endmodule

//--- verilog/alloc_dispatch.sv
//==========================================================
// Allocation dispatcher
// Steers requests and frees to the addressed bank and
// returns that bank's ack, no latency in either direction
//==========================================================

`timescale 1ns/1ps

`include "alloc_params.svh"

module alloc_dispatch (
	// Requester side
	input  logic                     i_alloc_rdy,
	input  alloc_pkg::alloc_req_t    i_alloc,
	output logic                     o_alloc_ack,
	// Bank side, alloc channel
	output logic [`ALLOC_N_BUF-1:0]  o_bank_rdy,
	input  logic [`ALLOC_N_BUF-1:0]  i_bank_ack,
	// Free pulses
	input  logic                     i_free_dval,
	input  alloc_pkg::free_req_t     i_free,
	output logic [`ALLOC_N_BUF-1:0]  o_bank_free
);

	//==========================================================
	// Alloc steering
	//==========================================================

	// Only the addressed bank sees rdy
	always_comb begin
		o_bank_rdy = '0;
		if (i_alloc_rdy) begin
			o_bank_rdy[i_alloc.bank] = 1'b1;
		end
	end

	// Ack back from the addressed bank alone
	// other banks have rdy low and never ack anyway
	always_comb begin
		o_alloc_ack = i_alloc_rdy & i_bank_ack[i_alloc.bank];
	end

	//==========================================================
	// Free steering
	//==========================================================

	// One-hot decode of the free pulse
	// payload itself is shared by all banks
	always_comb begin
		o_bank_free = '0;
		if (i_free_dval) begin
			o_bank_free[i_free.bank] = 1'b1;
		end
	end

endmodule

//--- verilog/alloc_pkg.sv
//==========================================================
// Buffer allocator types
// Request, free, grant and size table structs
//==========================================================

`include "alloc_params.svh"

package alloc_pkg;

	// One table entry, one bit wider than an address
	// so that a full bank fits
	typedef logic [`ALLOC_LBW:0] size_t;

	// Size per configuration id, shared by all banks
	typedef size_t [`ALLOC_N_CFG-1:0] size_tab_t;

	// Allocation request from the requester
	typedef struct packed {
		logic [`ALLOC_BUF_BW-1:0] bank;
		logic [`ALLOC_CFG_BW-1:0] cfg;
		logic                     is_false;
	} alloc_req_t;

	// Free pulse payload
	typedef struct packed {
		logic [`ALLOC_BUF_BW-1:0] bank;
		logic [`ALLOC_CFG_BW-1:0] cfg;
		logic                     is_false;
	} free_req_t;

	// Granted space, address is local to the bank
	typedef struct packed {
		logic [`ALLOC_BUF_BW-1:0] bank;
		logic [`ALLOC_LBW-1:0]    addr;
		logic [`ALLOC_CFG_BW-1:0] cfg;
		logic                     is_false;
	} grant_t;

endpackage

//--- verilog/alloc_params.svh
//==========================================================
// Buffer allocator parameters
// Bank count, local address width and size table depth
//==========================================================

`ifndef ALLOC_PARAMS_SVH
`define ALLOC_PARAMS_SVH

// Number of local buffer banks
`define ALLOC_N_BUF 4
// Bank index width, log2 of the bank count
`define ALLOC_BUF_BW 2

// Local address width, each bank holds 2**LBW words
`define ALLOC_LBW 6

// Entries in the shared size table
`define ALLOC_N_CFG 4
// Configuration id width
`define ALLOC_CFG_BW 2

`endif
